// ==== Makefile ====
SIM := verilator
SIM_FLAGS := --binary --timing --assert -Wno-fatal
TOP := fpMulUnit_tb
FILE_LIST := fpMul.f

BUILD_DIR := obj_dir
SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILE_LIST))
PASS_TEXT := ** PASS **

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

// ==== fpExpPath.sv ====
`timescale 1ns/1ps

module fpExpPath
(
	input logic clock,
	input logic reset,
	input logic hold,
	input fpMulPkg::mulReqT request,
	output fpMulPkg::expInfoT expInfo
);
	import fpMulPkg::*;

	// raw exponent fields of both operands
	logic [expWidth-1:0] expA;
	logic [expWidth-1:0] expB;

	logic zeroA;
	logic zeroB;
	logic infA;
	logic infB;

	// decoded info for the incoming pair
	expInfoT stageNext;

	// delay line that keeps the exponent aligned with the significand product
	expInfoT stage [pathStages];

	always_comb
	begin
		expA = fieldExp(request.a);
		expB = fieldExp(request.b);

		// subnormals count as zero, NaNs count as infinity
		zeroA = (expA == '0);
		zeroB = (expB == '0);
		infA = (expA == expWidth'(expMax));
		infB = (expB == expWidth'(expMax));

		stageNext.valid = request.valid;
		stageNext.sign = fieldSign(request.a) ^ fieldSign(request.b);

		// sum of biased exponents leaves one extra bias to remove
		stageNext.exp = expT'(expA) + expT'(expB) - expT'(expBias);

		// a zero operand wins over an infinite one
		stageNext.isZero = zeroA || zeroB;
		stageNext.isInf = (infA || infB) && !(zeroA || zeroB);
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			// only the valid bits are cleared, payload keeps its value
			for (int i = 0; i < pathStages; i++)
			begin
				stage[i].valid <= 1'b0;
			end
		end
		else if (!hold)
		begin
			stage[0] <= stageNext;
			for (int i = 1; i < pathStages; i++)
			begin
				stage[i] <= stage[i-1];
			end
		end
	end

	// last stage lines up with the registered product
	assign expInfo = stage[pathStages-1];

endmodule

// ==== fpFracPath.sv ====
`timescale 1ns/1ps

module fpFracPath
(
	input logic clock,
	input logic reset,
	input logic hold,
	input fpMulPkg::mulReqT request,
	output fpMulPkg::fracInfoT fracInfo
);
	import fpMulPkg::*;

	// one limb by limb partial product
	typedef logic [2*$bits(limbT)-1:0] partT;

	// sum and carry vectors of a 3:2 compressor
	typedef struct packed {
		prodT sum;
		prodT carry;
	} csaT;

	// significands with the hidden bit attached
	fracT fracA;
	fracT fracB;

	// three limbs per operand, least significant first
	limbT limbA [3];
	limbT limbB [3];

	// stage 1 products, indexed by limb of a then limb of b
	partT partNext [3][3];
	partT partReg [3][3];

	// shifted rows fed into the reduction
	prodT rowA;
	prodT rowB;
	prodT rowC;
	prodT rowD;
	prodT rowE;

	csaT levelOne;
	csaT levelTwo;
	csaT levelThree;

	// stage 2 partial sums
	prodT sumReg;
	prodT carryReg;

	// stage 3 exact product
	prodT prodReg;

	// tracks which stages hold a real item
	logic validOne;
	logic validTwo;

	function automatic csaT carrySave(prodT x, prodT y, prodT z);
		csaT result;
		result.sum = x ^ y ^ z;
		result.carry = ((x & y) | (x & z) | (y & z)) << 1;
		return result;
	endfunction

	// stage 1: limb split and nine products
	always_comb
	begin
		fracA = {1'b1, fieldFrac(request.a)};
		fracB = {1'b1, fieldFrac(request.b)};

		limbA[0] = fracA[17:0];
		limbA[1] = fracA[35:18];
		// top limb only has 17 bits of significand
		limbA[2] = limbT'(fracA[52:36]);

		limbB[0] = fracB[17:0];
		limbB[1] = fracB[35:18];
		limbB[2] = limbT'(fracB[52:36]);

		for (int i = 0; i < 3; i++)
		begin
			for (int j = 0; j < 3; j++)
			begin
				partNext[i][j] = partT'(limbA[i]) * partT'(limbB[j]);
			end
		end
	end

	// stage 2: five rows, each product at an offset of 18 times its limb weight
	always_comb
	begin
		// weights 0, 2 and 4 never overlap, so they share one row
		rowA = prodT'({partReg[2][2], partReg[1][1], partReg[0][0]});
		rowB = prodT'({partReg[2][1], partReg[1][0], 18'd0});
		rowC = prodT'({partReg[1][2], partReg[0][1], 18'd0});
		rowD = prodT'({partReg[2][0], 36'd0});
		rowE = prodT'({partReg[0][2], 36'd0});

		// 5 rows down to 2 with three carry-save levels
		levelOne = carrySave(rowA, rowB, rowC);
		levelTwo = carrySave(rowD, rowE, levelOne.sum);
		levelThree = carrySave(levelTwo.sum, levelOne.carry, levelTwo.carry);
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			validOne <= 1'b0;
			validTwo <= 1'b0;
		end
		else if (!hold)
		begin
			validOne <= request.valid;
			validTwo <= validOne;
		end
	end

	// datapath registers only load for real items to save toggling on bubbles
	always_ff @(posedge clock)
	begin
		if (!hold && request.valid)
		begin
			for (int i = 0; i < 3; i++)
			begin
				for (int j = 0; j < 3; j++)
				begin
					partReg[i][j] <= partNext[i][j];
				end
			end
		end

		if (!hold && validOne)
		begin
			sumReg <= levelThree.sum;
			carryReg <= levelThree.carry;
		end

		// stage 3: final carry propagate add
		if (!hold && validTwo)
		begin
			prodReg <= sumReg + carryReg;
		end
	end

	assign fracInfo.prod = prodReg;

endmodule

// ==== fpMul.f ====
fpMulPkg.sv
fpExpPath.sv
fpFracPath.sv
fpNormPack.sv
fpMulUnit.sv
fpMulUnit_asserts.sv
fpMulUnit_tb.sv

// ==== fpMulPkg.sv ====
package fpMulPkg;

	// raw and intermediate widths of the Binary64 multiplier
	typedef logic [63:0] float64T;
	typedef logic [52:0] fracT;
	typedef logic [17:0] limbT;
	typedef logic [105:0] prodT;

	// biased exponent with room for overflow and a two's complement underflow
	typedef logic [12:0] expT;

	// Binary64 field layout
	localparam int fracWidth = 52;
	localparam int expWidth = 11;
	localparam int signPos = 63;

	localparam int expBias = 1023;
	localparam int expMax = 2047;

	// request to response latency in unheld cycles
	localparam int pipeDepth = 4;

	// both operand paths run one stage shorter than the whole unit
	localparam int pathStages = pipeDepth - 1;

	typedef struct packed {
		logic valid;
		float64T a;
		float64T b;
	} mulReqT;

	typedef struct packed {
		logic valid;
		logic sign;
		expT exp;
		logic isZero;
		logic isInf;
	} expInfoT;

	typedef struct packed {
		prodT prod;
	} fracInfoT;

	typedef struct packed {
		logic valid;
		float64T result;
	} mulRespT;

	function automatic logic fieldSign(float64T value);
		return value[signPos];
	endfunction

	function automatic logic [expWidth-1:0] fieldExp(float64T value);
		return value[fracWidth +: expWidth];
	endfunction

	function automatic logic [fracWidth-1:0] fieldFrac(float64T value);
		return value[fracWidth-1:0];
	endfunction

endpackage

// ==== fpMulUnit.sv ====
`timescale 1ns/1ps

module fpMulUnit
(
	input logic clock,
	input logic reset,
	input logic hold,
	input fpMulPkg::mulReqT request,
	output fpMulPkg::mulRespT response
);
	import fpMulPkg::*;

	// both paths finish in the same cycle and meet at the packer
	expInfoT expInfo;
	fracInfoT fracInfo;

	// sign, exponent and special cases
	fpExpPath i_expPath
	(
		.clock(clock),
		.reset(reset),
		.hold(hold),
		.request(request),
		.expInfo(expInfo)
	);

	// exact significand product
	fpFracPath i_fracPath
	(
		.clock(clock),
		.reset(reset),
		.hold(hold),
		.request(request),
		.fracInfo(fracInfo)
	);

	// normalize, round and pack into the response register
	fpNormPack i_normPack
	(
		.clock(clock),
		.reset(reset),
		.hold(hold),
		.expInfo(expInfo),
		.fracInfo(fracInfo),
		.response(response)
	);

endmodule

// ==== fpMulUnit_asserts.sv ====
`timescale 1ns/1ps

module fpMulUnit_asserts
(
	input logic clock,
	input logic reset,
	input logic hold,
	input fpMulPkg::mulReqT request,
	input fpMulPkg::mulRespT response
);
	import fpMulPkg::*;

	// consecutive edges with neither hold nor reset up to the depth
	int unheldRun;

	// failed assertions seen so far
	int failCount = 0;

	always_ff @(posedge clock)
	begin
		if (reset || hold)
		begin
			unheldRun <= 0;
		end
		else if (unheldRun < pipeDepth)
		begin
			unheldRun <= unheldRun + 1;
		end
	end

	property validClearedByReset;
		@(posedge clock) reset |=> !response.valid;
	endproperty

	property stableUnderHold;
		@(posedge clock) disable iff (reset)
			hold |=> $stable(response);
	endproperty

	// bubbles travel like items, so valid simply follows the input
	property validFollowsRequest;
		@(posedge clock) disable iff (reset)
			(unheldRun == pipeDepth) |-> (response.valid == $past(request.valid, pipeDepth));
	endproperty

	resetClearsValid: assert property (validClearedByReset)
		else
		begin
			failCount++;
			$error("response valid is set in the cycle after reset");
		end

	holdKeepsResponse: assert property (stableUnderHold)
		else
		begin
			failCount++;
			$error("response changed while the pipeline was held");
		end

	latencyMatches: assert property (validFollowsRequest)
		else
		begin
			failCount++;
			$error("response valid does not match the request valid from pipeDepth cycles back");
		end

endmodule

// ==== fpMulUnit_tb.sv ====
`timescale 1ns/1ps

module fpMulUnit_tb;
	import fpMulPkg::*;

	localparam real clockPeriod = 40.0;
	localparam int resetCycles = 16;
	localparam int randomCount = 200;
	localparam int zeroCount = 40;
	localparam int specialCount = 60;
	localparam int carryCount = 40;
	localparam int holdCount = 200;
	localparam int drainCycles = 16;

	// a held item can cost up to six cycles
	localparam int testCycles = resetCycles + randomCount + zeroCount + specialCount
		+ carryCount + holdCount * 6 + 5 * drainCycles;
	localparam int watchdogCycles = testCycles + 500;

	logic clock;
	logic reset;
	logic hold;
	mulReqT request;
	mulRespT response;

	// expected results in request order
	float64T expectQ[$];

	int checkCount = 0;
	int errorCount = 0;
	int testCount = 0;
	int checkStart;
	int errorStart;
	logic [31:0] lcgState = 32'h82c8;

	fpMulUnit i_dut
	(
		.clock(clock),
		.reset(reset),
		.hold(hold),
		.request(request),
		.response(response)
	);

	bind fpMulUnit fpMulUnit_asserts i_asserts
	(
		.clock(clock),
		.reset(reset),
		.hold(hold),
		.request(request),
		.response(response)
	);

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic logic coinFlip();
		logic [31:0] value;
		value = nextRandom();
		return value[16];
	endfunction

	function automatic logic [51:0] randomFrac();
		logic [63:0] bits;
		bits = {nextRandom(), nextRandom()};
		return bits[51:0];
	endfunction

	function automatic logic [10:0] moderateExp();
		return 11'(823 + nextRandom() % 400);
	endfunction

	function automatic float64T makeFloat(logic sign, logic [10:0] expField, logic [51:0] frac);
		return {sign, expField, frac};
	endfunction

	function automatic float64T normalOperand();
		return makeFloat(coinFlip(), moderateExp(), randomFrac());
	endfunction

	// expected product from the format rules on plain integers
	function automatic float64T expectedProduct(float64T a, float64T b);
		logic sign;
		int expA;
		int expB;
		int expSum;
		logic [105:0] product;
		logic [52:0] kept;
		sign = a[63] ^ b[63];
		expA = int'(a[62:52]);
		expB = int'(b[62:52]);
		if (expA == 0 || expB == 0)
		begin
			return '0;
		end
		if (expA == expMax || expB == expMax)
		begin
			return {sign, 11'h7ff, 52'd0};
		end
		product = {53'd0, 1'b1, a[51:0]} * {53'd0, 1'b1, b[51:0]};
		expSum = expA + expB - expBias;
		if (product[105])
		begin
			kept = {1'b0, product[104:53]} + 53'(product[52]);
			expSum++;
		end
		else
		begin
			kept = {1'b0, product[103:52]} + 53'(product[51]);
		end
		// carry out of the rounding leaves the fraction bits at zero
		if (kept[52])
		begin
			expSum++;
		end
		if (expSum <= 0)
		begin
			return '0;
		end
		if (expSum >= expMax)
		begin
			return {sign, 11'h7ff, 52'd0};
		end
		return {sign, expSum[10:0], kept[51:0]};
	endfunction

	initial
	begin
		clock = 1'b0;
		forever #(clockPeriod / 2) clock = ~clock;
	end

	initial
	begin
		#(watchdogCycles * clockPeriod);
		$display("timeout: the tests did not finish within %0d clock cycles", watchdogCycles);
		$display("** FAIL **");
		$finish;
	end

	// a response is consumed on the edge that replaces it
	always @(posedge clock)
	begin
		float64T expected;
		if (!reset && !hold)
		begin
			if (response.valid)
			begin
				if (expectQ.size() == 0)
				begin
					$display("a valid response came out with no request outstanding");
					errorCount++;
				end
				else
				begin
					expected = expectQ.pop_front();
					checkCount++;
					assert (response.result == expected)
					else
					begin
						$display("error: response.result is %h, expected %h",
							response.result, expected);
						errorCount++;
					end
				end
			end
			if (request.valid)
			begin
				expectQ.push_back(expectedProduct(request.a, request.b));
			end
		end
	end

	task automatic sendPair(float64T a, float64T b);
		@(posedge clock);
		request.valid <= 1'b1;
		request.a <= a;
		request.b <= b;
		hold <= 1'b0;
	endtask

	task automatic driveEitherOrder(float64T x, float64T y);
		if (coinFlip())
		begin
			sendPair(x, y);
		end
		else
		begin
			sendPair(y, x);
		end
	endtask

	// holds the pipeline while junk sits on the input
	task automatic applyHold(int cycles);
		repeat (cycles)
		begin
			@(posedge clock);
			hold <= 1'b1;
			request.valid <= 1'b1;
			request.a <= normalOperand();
			request.b <= normalOperand();
		end
	endtask

	task automatic startTest();
		checkStart = checkCount;
		errorStart = errorCount;
	endtask

	task automatic finishTest(string name);
		@(posedge clock);
		request.valid <= 1'b0;
		hold <= 1'b0;
		while (expectQ.size() != 0)
		begin
			@(negedge clock);
		end
		testCount++;
		$display("test %0d %s: %0d checks, %0d errors", testCount, name,
			checkCount - checkStart, errorCount - errorStart);
	endtask

	task automatic multiplyRandomNormals();
		startTest();
		for (int i = 0; i < randomCount; i++)
		begin
			sendPair(normalOperand(), normalOperand());
		end
		finishTest("random normals");
	endtask

	task automatic checkZeroOperands();
		float64T zeroSide;
		float64T otherSide;
		startTest();
		for (int i = 0; i < zeroCount; i++)
		begin
			// signed zero or a subnormal
			zeroSide = makeFloat(coinFlip(), 11'd0, (i % 2 == 0) ? 52'd0 : randomFrac());
			case (i % 3)
				0: otherSide = normalOperand();
				1: otherSide = makeFloat(coinFlip(), 11'h7ff, 52'd0);
				default: otherSide = makeFloat(coinFlip(), 11'h7ff, randomFrac() | 52'd1);
			endcase
			driveEitherOrder(zeroSide, otherSide);
		end
		finishTest("zero and subnormal operands");
	endtask

	task automatic coverSpecialCases();
		startTest();
		for (int i = 0; i < specialCount; i++)
		begin
			case (i % 4)
				0: driveEitherOrder(makeFloat(coinFlip(), 11'h7ff, 52'd0), normalOperand());
				1: driveEitherOrder(makeFloat(coinFlip(), 11'h7ff, randomFrac() | 52'd1),
					normalOperand());
				// exponent sum far above the range
				2: sendPair(makeFloat(coinFlip(), 11'(1600 + nextRandom() % 400), randomFrac()),
					makeFloat(coinFlip(), 11'(1600 + nextRandom() % 400), randomFrac()));
				default: sendPair(makeFloat(coinFlip(), 11'(1 + nextRandom() % 400), randomFrac()),
					makeFloat(coinFlip(), 11'(1 + nextRandom() % 400), randomFrac()));
			endcase
		end
		finishTest("infinity, nan, overflow and underflow");
	endtask

	task automatic forceRoundingCarry();
		logic [63:0] x;
		logic [51:0] fracA;
		logic [51:0] fracB;
		startTest();
		for (int i = 0; i < carryCount; i++)
		begin
			// (1 + x) times (2 - 2x) lands just under 2 and rounds up
			x = 64'(1 + nextRandom() % 32'h0200_0000);
			fracA = 52'(x);
			fracB = 52'(64'h0010_0000_0000_0000 - 2 * x);
			if (i % 4 == 3)
			begin
				fracA = '1;
				fracB = '1;
			end
			driveEitherOrder(makeFloat(coinFlip(), moderateExp(), fracA),
				makeFloat(coinFlip(), moderateExp(), fracB));
		end
		finishTest("rounding carry");
	endtask

	task automatic streamWithHold();
		startTest();
		for (int i = 0; i < holdCount; i++)
		begin
			sendPair(normalOperand(), normalOperand());
			if (nextRandom() % 3 == 0)
			begin
				applyHold(1 + int'(nextRandom() % 5));
			end
		end
		finishTest("back to back with hold");
	endtask

	initial
	begin
		reset = 1'b1;
		hold = 1'b0;
		request = '0;
		repeat (resetCycles) @(posedge clock);
		reset <= 1'b0;

		multiplyRandomNormals();
		checkZeroOperands();
		coverSpecialCases();
		forceRoundingCarry();
		streamWithHold();

		$display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
			testCount, checkCount, errorCount, i_dut.i_asserts.failCount);
		if (errorCount == 0 && i_dut.i_asserts.failCount == 0 && checkCount > 0)
		begin
			$display("** PASS **");
		end
		else
		begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== fpNormPack.sv ====
`timescale 1ns/1ps

module fpNormPack
(
	input logic clock,
	input logic reset,
	input logic hold,
	input fpMulPkg::expInfoT expInfo,
	input fpMulPkg::fracInfoT fracInfo,
	output fpMulPkg::mulRespT response
);
	import fpMulPkg::*;

	prodT prod;

	// fraction bits kept after normalization and the bit below them
	logic [fracWidth-1:0] keep;
	logic roundBit;

	// one extra bit catches the carry out of rounding
	logic [fracWidth:0] rounded;

	expT expNorm;
	expT expFinal;

	logic toZero;
	logic toInf;

	float64T packedResult;

	always_comb
	begin
		prod = fracInfo.prod;

		// product of two significands in [1,2) lies in [1,4)
		if (prod[105])
		begin
			keep = prod[104:53];
			roundBit = prod[52];
			expNorm = expInfo.exp + expT'(1);
		end
		else
		begin
			keep = prod[103:52];
			roundBit = prod[51];
			expNorm = expInfo.exp;
		end

		// round half up, a carry out leaves the fraction at zero
		rounded = {1'b0, keep} + {{fracWidth{1'b0}}, roundBit};
		expFinal = expNorm + expT'(rounded[fracWidth]);

		toZero = expInfo.isZero || ($signed(expFinal) <= 0);
		toInf = expInfo.isInf || ($signed(expFinal) >= expMax);

		if (toZero)
		begin
			// underflow and zero operands always give +0
			packedResult = '0;
		end
		else if (toInf)
		begin
			packedResult = {expInfo.sign, expWidth'(expMax), {fracWidth{1'b0}}};
		end
		else
		begin
			packedResult = {expInfo.sign, expFinal[expWidth-1:0], rounded[fracWidth-1:0]};
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			response <= '0;
		end
		else if (!hold)
		begin
			response.valid <= expInfo.valid;
			response.result <= packedResult;
		end
	end

endmodule
